/* Bender.yml */
package:
  name: s4_carry

sources:
  - src/s4_width_pkg.sv
  - src/s4_code_pkg.sv
  - src/s4_prebit_decode.sv
  - src/s4_carry_execute.sv
  - src/s4_bitstream_result.sv
  - src/s4_carry_top.sv
  - target: test
    files:
      - test/s4_clock_gen.sv
      - test/s4_carry_checker.sv
      - test/s4_tb.sv

/* src/s4_bitstream_result.sv */
// Output holds zero for settle_cycles clock edges after arst_n releases
`timescale 1ns/10ps
`default_nettype none

module s4_bitstream_result (
  input  wire                              s4_clk,
  input  wire                              arst_n,
  input  wire [s4_width_pkg::byte_w-1:0]   byte_1,
  input  wire [s4_width_pkg::byte_w-1:0]   byte_2,
  input  wire [s4_width_pkg::byte_w-1:0]   byte_3,
  input  wire [s4_width_pkg::byte_w-1:0]   byte_4,
  input  wire [s4_width_pkg::byte_w-1:0]   byte_5,
  input  wire [s4_width_pkg::count_w-1:0]  byte_count,
  input  wire                              last,
  output logic [s4_width_pkg::byte_w-1:0]  out_byte_1,
  output logic [s4_width_pkg::byte_w-1:0]  out_byte_2,
  output logic [s4_width_pkg::byte_w-1:0]  out_byte_3,
  output logic [s4_width_pkg::byte_w-1:0]  out_byte_4,
  output logic [s4_width_pkg::byte_w-1:0]  out_byte_5,
  output logic [s4_width_pkg::count_w-1:0] out_count,
  output logic                             out_last
);

  logic [s4_width_pkg::settle_w-1:0] settle_q;
  logic                              out_en;

  // Upstream state may still be settling right after reset
  assign out_en = (settle_q == s4_width_pkg::settle_cycles);

  always_ff @(posedge s4_clk or negedge arst_n) begin
    if (!arst_n) begin
      settle_q   <= '0;
      out_byte_1 <= '0;
      out_byte_2 <= '0;
      out_byte_3 <= '0;
      out_byte_4 <= '0;
      out_byte_5 <= '0;
      out_count  <= '0;
      out_last   <= 1'b0;
    end else if (!out_en) begin
      settle_q <= settle_q + 1'b1;
    end else begin
      out_byte_1 <= byte_1;
      out_byte_2 <= byte_2;
      out_byte_3 <= byte_3;
      out_byte_4 <= byte_4;
      out_byte_5 <= byte_5;
      out_count  <= byte_count;
      out_last   <= last;
    end
  end

endmodule

`default_nettype wire

/* src/s4_carry_execute.sv */
// At flush the pending 0xFF run must be at most two, or the final cycle overflows five slots
`timescale 1ns/10ps
`default_nettype none

module s4_carry_execute (
  input  wire                              s4_clk,
  input  wire                              arst_n,
  input  wire                              flag_first,
  input  wire [s4_width_pkg::word_w-1:0]   word_1,
  input  wire [s4_width_pkg::word_w-1:0]   word_2,
  input  wire [1:0]                        word_count,
  input  wire                              final_words,
  output logic [s4_width_pkg::byte_w-1:0]  byte_1,
  output logic [s4_width_pkg::byte_w-1:0]  byte_2,
  output logic [s4_width_pkg::byte_w-1:0]  byte_3,
  output logic [s4_width_pkg::byte_w-1:0]  byte_4,
  output logic [s4_width_pkg::byte_w-1:0]  byte_5,
  output logic [s4_width_pkg::count_w-1:0] byte_count,
  output logic                             last
);

  // Held state between cycles
  logic [s4_width_pkg::byte_w-1:0]  prev_q;
  logic                             prev_vld_q;
  logic [s4_width_pkg::run_w-1:0]   run_q;

  // Working copies while the words of this cycle are applied
  logic [s4_width_pkg::byte_w-1:0]  cur_prev;
  logic                             cur_vld;
  logic [s4_width_pkg::run_w-1:0]   cur_run;
  logic [s4_width_pkg::word_w-1:0]  cur_word;
  logic                             cur_carry;
  logic                             step_act;

  logic [s4_width_pkg::byte_w-1:0]  slot [s4_width_pkg::max_out];
  logic [s4_width_pkg::count_w-1:0] n_out;

  // ------------------------------
  // Carry resolution
  // ------------------------------
  // Steps 0 and 1 take the two words, step 2 drains on flush
  always_comb begin
    cur_prev  = prev_q;
    cur_vld   = prev_vld_q & ~flag_first;
    cur_run   = flag_first ? '0 : run_q;
    cur_word  = '0;
    cur_carry = 1'b0;
    step_act  = 1'b0;
    n_out     = '0;
    for (int k = 0; k < s4_width_pkg::max_out; k++) begin
      slot[k] = '0;
    end

    for (int step = 0; step < 3; step++) begin
      case (step)
        0: begin
          cur_word = word_1;
          step_act = (word_count >= 2'd1);
        end
        1: begin
          cur_word = word_2;
          step_act = (word_count == 2'd2);
        end
        default: begin
          // Zero byte with carry clear settles everything still held
          cur_word = '0;
          step_act = final_words;
        end
      endcase
      cur_carry = cur_word[s4_width_pkg::byte_w];

      if (step_act) begin
        if (step < 2 && !cur_carry &&
            cur_word[s4_width_pkg::byte_w-1:0] == s4_code_pkg::run_byte) begin
          cur_run = cur_run + 1'b1;
        end else begin
          if (cur_vld) begin
            if (n_out < s4_width_pkg::max_out) begin
              slot[n_out] = cur_prev + cur_carry;
            end
            n_out = n_out + 1'b1;
          end
          // Pending 0xFF bytes wrap to 0x00 on a carry
          for (int r = 0; r < s4_width_pkg::max_run; r++) begin
            if (r < cur_run) begin
              if (n_out < s4_width_pkg::max_out) begin
                slot[n_out] = s4_code_pkg::run_byte + cur_carry;
              end
              n_out = n_out + 1'b1;
            end
          end
          cur_prev = cur_word[s4_width_pkg::byte_w-1:0];
          cur_vld  = 1'b1;
          cur_run  = '0;
        end
      end
    end
  end

  // ------------------------------
  // State update
  // ------------------------------
  always_ff @(posedge s4_clk or negedge arst_n) begin
    if (!arst_n) begin
      prev_vld_q <= 1'b0;
      run_q      <= '0;
    end else begin
      prev_vld_q <= final_words ? 1'b0 : cur_vld;
      run_q      <= final_words ? '0 : cur_run;
    end
  end

  always_ff @(posedge s4_clk) begin
    prev_q <= cur_prev;
  end

  assign byte_1     = slot[0];
  assign byte_2     = slot[1];
  assign byte_3     = slot[2];
  assign byte_4     = slot[3];
  assign byte_5     = slot[4];
  assign byte_count = n_out;
  assign last       = final_words;

endmodule

`default_nettype wire

/* src/s4_carry_top.sv */
// No back-pressure; every nonzero out_count must be taken in its cycle
`timescale 1ns/10ps
`default_nettype none

module s4_carry_top (
  input  wire                              s4_clk,
  input  wire                              arst_n,
  input  wire                              flag_first,
  input  wire [s4_width_pkg::word_w-1:0]   pb_1_1,
  input  wire [s4_width_pkg::word_w-1:0]   pb_1_2,
  input  wire [s4_width_pkg::word_w-1:0]   pb_2_1,
  input  wire [s4_width_pkg::word_w-1:0]   pb_2_2,
  input  wire [1:0]                        pb_flag_1,
  input  wire [1:0]                        pb_flag_2,
  input  wire                              flush,
  input  wire [s4_width_pkg::low_w-1:0]    low,
  input  wire [s4_width_pkg::cnt_w-1:0]    cnt,
  output logic [s4_width_pkg::byte_w-1:0]  out_byte_1,
  output logic [s4_width_pkg::byte_w-1:0]  out_byte_2,
  output logic [s4_width_pkg::byte_w-1:0]  out_byte_3,
  output logic [s4_width_pkg::byte_w-1:0]  out_byte_4,
  output logic [s4_width_pkg::byte_w-1:0]  out_byte_5,
  output logic [s4_width_pkg::count_w-1:0] out_count,
  output logic                             out_last
);

  logic [s4_width_pkg::word_w-1:0]  word_1;
  logic [s4_width_pkg::word_w-1:0]  word_2;
  logic [1:0]                       word_count;
  logic                             final_words;
  logic [s4_width_pkg::byte_w-1:0]  byte_1;
  logic [s4_width_pkg::byte_w-1:0]  byte_2;
  logic [s4_width_pkg::byte_w-1:0]  byte_3;
  logic [s4_width_pkg::byte_w-1:0]  byte_4;
  logic [s4_width_pkg::byte_w-1:0]  byte_5;
  logic [s4_width_pkg::count_w-1:0] byte_count;
  logic                             last;

  // ------------------------------
  // Decode, execute, result
  // ------------------------------
  s4_prebit_decode decode_i (
    .s4_clk      (s4_clk),
    .arst_n      (arst_n),
    .pb_1_1      (pb_1_1),
    .pb_1_2      (pb_1_2),
    .pb_2_1      (pb_2_1),
    .pb_2_2      (pb_2_2),
    .pb_flag_1   (pb_flag_1),
    .pb_flag_2   (pb_flag_2),
    .flush       (flush),
    .low         (low),
    .cnt         (cnt),
    .word_1      (word_1),
    .word_2      (word_2),
    .word_count  (word_count),
    .final_words (final_words)
  );

  s4_carry_execute execute_i (
    .s4_clk      (s4_clk),
    .arst_n      (arst_n),
    .flag_first  (flag_first),
    .word_1      (word_1),
    .word_2      (word_2),
    .word_count  (word_count),
    .final_words (final_words),
    .byte_1      (byte_1),
    .byte_2      (byte_2),
    .byte_3      (byte_3),
    .byte_4      (byte_4),
    .byte_5      (byte_5),
    .byte_count  (byte_count),
    .last        (last)
  );

  s4_bitstream_result result_i (
    .s4_clk     (s4_clk),
    .arst_n     (arst_n),
    .byte_1     (byte_1),
    .byte_2     (byte_2),
    .byte_3     (byte_3),
    .byte_4     (byte_4),
    .byte_5     (byte_5),
    .byte_count (byte_count),
    .last       (last),
    .out_byte_1 (out_byte_1),
    .out_byte_2 (out_byte_2),
    .out_byte_3 (out_byte_3),
    .out_byte_4 (out_byte_4),
    .out_byte_5 (out_byte_5),
    .out_count  (out_count),
    .out_last   (out_last)
  );

endmodule

`default_nettype wire

/* src/s4_code_pkg.sv */
// Lane flag values double as the number of valid words in the lane
`default_nettype none

package s4_code_pkg;

  // ------------------------------
  // Lane flags
  // ------------------------------
  localparam logic [1:0] lane_none = 2'd0;
  localparam logic [1:0] lane_one  = 2'd1;
  localparam logic [1:0] lane_two  = 2'd2;

  // ------------------------------
  // Flush and carry constants
  // ------------------------------
  // Rounding mask for the final low value
  localparam logic [13:0] flush_mask = 14'h3fff;

  // Byte value that stays pending until a later carry decision
  localparam logic [7:0] run_byte = 8'hff;

endpackage

`default_nettype wire

/* src/s4_prebit_decode.sv */
// Flush must come one cycle after the last lane word; flag value 3 counts as no words
`timescale 1ns/10ps
`default_nettype none

module s4_prebit_decode (
  input  wire                              s4_clk,
  input  wire                              arst_n,
  input  wire [s4_width_pkg::word_w-1:0]   pb_1_1,
  input  wire [s4_width_pkg::word_w-1:0]   pb_1_2,
  input  wire [s4_width_pkg::word_w-1:0]   pb_2_1,
  input  wire [s4_width_pkg::word_w-1:0]   pb_2_2,
  input  wire [1:0]                        pb_flag_1,
  input  wire [1:0]                        pb_flag_2,
  input  wire                              flush,
  input  wire [s4_width_pkg::low_w-1:0]    low,
  input  wire [s4_width_pkg::cnt_w-1:0]    cnt,
  output logic [s4_width_pkg::word_w-1:0]  word_1,
  output logic [s4_width_pkg::word_w-1:0]  word_2,
  output logic [1:0]                       word_count,
  output logic                             final_words
);

  logic [1:0]                       sel_flag;
  logic [1:0]                       lane_count;
  logic [s4_width_pkg::word_w-1:0]  lane_w1;
  logic [s4_width_pkg::word_w-1:0]  lane_w2;

  logic [s4_width_pkg::low_w:0]     mask_ext;
  logic [s4_width_pkg::low_w:0]     flush_e;
  logic [s4_width_pkg::low_w:0]     e_hi;
  logic [s4_width_pkg::low_w:0]     e_lo;
  logic [s4_width_pkg::cnt_w:0]     flush_s;
  logic [s4_width_pkg::cnt_w:0]     sh_hi;
  logic [s4_width_pkg::cnt_w:0]     sh_lo;
  logic [s4_width_pkg::word_w-1:0]  flush_w1;
  logic [s4_width_pkg::word_w-1:0]  flush_w2;
  logic [1:0]                       flush_count;

  logic [s4_width_pkg::word_w-1:0]  fin_w1_q;
  logic [s4_width_pkg::word_w-1:0]  fin_w2_q;
  logic [1:0]                       fin_count_q;
  logic                             final_q;

  // ------------------------------
  // Lane select
  // ------------------------------
  // Lane 1 has priority whenever it carries words
  assign sel_flag = (pb_flag_1 != s4_code_pkg::lane_none) ? pb_flag_1 : pb_flag_2;
  assign lane_w1  = (pb_flag_1 != s4_code_pkg::lane_none) ? pb_1_1 : pb_2_1;
  assign lane_w2  = (pb_flag_1 != s4_code_pkg::lane_none) ? pb_1_2 : pb_2_2;

  always_comb begin
    case (sel_flag)
      s4_code_pkg::lane_one: lane_count = 2'd1;
      s4_code_pkg::lane_two: lane_count = 2'd2;
      default:               lane_count = 2'd0;
    endcase
  end

  // ------------------------------
  // Flush words
  // ------------------------------
  assign mask_ext = s4_code_pkg::flush_mask;
  // Round low up, clear the mask bits and set the bit just above them
  assign flush_e  = (({1'b0, low} + mask_ext) & ~mask_ext) | (mask_ext + 1'b1);
  assign flush_s  = cnt + 5'd10;
  assign sh_hi    = cnt + 5'd16;
  assign sh_lo    = cnt + 5'd8;
  assign e_hi     = flush_e >> sh_hi;
  assign e_lo     = flush_e >> sh_lo;

  assign flush_w1    = e_hi[s4_width_pkg::word_w-1:0];
  // Second word never carries
  assign flush_w2    = {1'b0, e_lo[s4_width_pkg::word_w-2:0]};
  assign flush_count = (flush_s > 6'd8) ? 2'd2 : 2'd1;

  always_ff @(posedge s4_clk or negedge arst_n) begin
    if (!arst_n) begin
      final_q     <= 1'b0;
      fin_count_q <= 2'd0;
    end else begin
      final_q <= flush;
      if (flush) begin
        fin_count_q <= flush_count;
      end
    end
  end

  always_ff @(posedge s4_clk) begin
    if (flush) begin
      fin_w1_q <= flush_w1;
      fin_w2_q <= flush_w2;
    end
  end

  // Held flush words replace the lanes for one cycle
  assign final_words = final_q;
  assign word_1      = final_q ? fin_w1_q : lane_w1;
  assign word_2      = final_q ? fin_w2_q : lane_w2;
  assign word_count  = final_q ? fin_count_q : lane_count;

endmodule

`default_nettype wire

/* src/s4_width_pkg.sv */
// Widths assume 9-bit pre-bitstream words and a 24-bit encoder low register
`default_nettype none

package s4_width_pkg;

  // ------------------------------
  // Datapath widths
  // ------------------------------
  localparam int byte_w = 8;
  localparam int word_w = 9;
  localparam int low_w  = 24;
  localparam int cnt_w  = 5;

  // ------------------------------
  // Carry execute limits
  // ------------------------------
  // Encoder never produces a longer pending 0xFF run
  localparam int max_run = 3;
  localparam int run_w   = $clog2(max_run + 1);
  localparam int max_out = 5;
  localparam int count_w = 3;

  // ------------------------------
  // Output settle after reset
  // ------------------------------
  localparam int settle_cycles = 2;
  localparam int settle_w      = $clog2(settle_cycles + 1);

endpackage

`default_nettype wire

/* tb.f */
src/s4_width_pkg.sv
src/s4_code_pkg.sv
src/s4_prebit_decode.sv
src/s4_carry_execute.sv
src/s4_bitstream_result.sv
src/s4_carry_top.sv
test/s4_clock_gen.sv
test/s4_carry_checker.sv
test/s4_tb.sv

/* test/s4_carry_checker.sv */
// Bound to s4_carry_top and sees the decoded words, so lane selection is already applied
`timescale 1ns/10ps
`default_nettype none

module s4_carry_checker (
  input wire                             s4_clk,
  input wire                             arst_n,
  input wire                             flush,
  input wire [s4_width_pkg::word_w-1:0]  word_1,
  input wire [s4_width_pkg::word_w-1:0]  word_2,
  input wire [1:0]                       word_count,
  input wire                             final_words,
  input wire [s4_width_pkg::count_w-1:0] out_count,
  input wire                             out_last
);

  logic [s4_width_pkg::word_w-1:0] run_word;
  logic                            run_only;
  logic                            assert_fail;

  initial begin
    assert_fail = 1'b0;
  end

  assign run_word = {1'b0, s4_code_pkg::run_byte};
  // Every word of this cycle is a pending 0xFF
  assign run_only = !final_words && (word_count != 2'd0) && (word_1 == run_word) &&
                    ((word_count == 2'd1) || (word_2 == run_word));

  // ------------------------------
  // Reset and settle
  // ------------------------------
  assert property (@(posedge s4_clk)
    $rose(arst_n) |-> (out_count == '0 && !out_last) [*s4_width_pkg::settle_cycles])
    else begin
      $error("output is not quiet during the settle window");
      assert_fail = 1'b1;
    end

  // ------------------------------
  // Byte counts
  // ------------------------------
  assert property (@(posedge s4_clk) disable iff (!arst_n)
    out_count <= s4_width_pkg::max_out)
    else begin
      $error("out_count exceeds the slot limit");
      assert_fail = 1'b1;
    end

  // One word settles at most the held byte and the pending run
  assert property (@(posedge s4_clk) disable iff (!arst_n)
    (!final_words && word_count <= 2'd1) |=> out_count <= s4_width_pkg::max_run + 1)
    else begin
      $error("out_count too large for a single word");
      assert_fail = 1'b1;
    end

  assert property (@(posedge s4_clk) disable iff (!arst_n) run_only |=> out_count == '0)
    else begin
      $error("bytes emitted while only pending 0xFF words arrived");
      assert_fail = 1'b1;
    end

  // ------------------------------
  // Flush timing
  // ------------------------------
  assert property (@(posedge s4_clk) disable iff (!arst_n) flush |-> ##2 out_last)
    else begin
      $error("out_last did not follow flush after two cycles");
      assert_fail = 1'b1;
    end

  assert property (@(posedge s4_clk) disable iff (!arst_n) $rose(out_last) |-> $past(flush, 2))
    else begin
      $error("out_last rose without a flush two cycles earlier");
      assert_fail = 1'b1;
    end

endmodule

`default_nettype wire

/* test/s4_clock_gen.sv */
// Free-running 8 ns clock; arst_n releases on a falling edge after 8 cycles
`timescale 1ns/10ps
`default_nettype none

module s4_clock_gen (
  output logic s4_clk,
  output logic arst_n
);

  initial begin
    s4_clk = 1'b0;
    forever #4 s4_clk = ~s4_clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (8) @(posedge s4_clk);
    @(negedge s4_clk);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* test/s4_tb.sv */
// Random frames keep pending 0xFF runs at three or fewer and close on a settled word
`timescale 1ns/10ps
`default_nettype none

module s4_tb;

  localparam int n_frames = 12;
  // Longest frame in cycles, closing word included
  localparam int max_len = 10;
  localparam int word_bound = (n_frames + 1) * (2 * max_len + 2);
  localparam int watch_cycles = 50 * word_bound + 200;

  logic                              s4_clk;
  logic                              arst_n;
  logic                              flag_first;
  logic [s4_width_pkg::word_w-1:0]   pb_1_1;
  logic [s4_width_pkg::word_w-1:0]   pb_1_2;
  logic [s4_width_pkg::word_w-1:0]   pb_2_1;
  logic [s4_width_pkg::word_w-1:0]   pb_2_2;
  logic [1:0]                        pb_flag_1;
  logic [1:0]                        pb_flag_2;
  logic                              flush;
  logic [s4_width_pkg::low_w-1:0]    low;
  logic [s4_width_pkg::cnt_w-1:0]    cnt;
  logic [s4_width_pkg::byte_w-1:0]   out_byte_1;
  logic [s4_width_pkg::byte_w-1:0]   out_byte_2;
  logic [s4_width_pkg::byte_w-1:0]   out_byte_3;
  logic [s4_width_pkg::byte_w-1:0]   out_byte_4;
  logic [s4_width_pkg::byte_w-1:0]   out_byte_5;
  logic [s4_width_pkg::count_w-1:0]  out_count;
  logic                              out_last;

  // Reference model state
  logic [31:0] lfsr_state;
  logic [7:0]  prev_byte;
  logic        prev_vld;
  int          run_cnt;
  logic [7:0]  exp_q [$];
  logic        last_seen;

  s4_clock_gen clk_gen_i (
    .s4_clk (s4_clk),
    .arst_n (arst_n)
  );

  s4_carry_top dut_i (
    .s4_clk     (s4_clk),
    .arst_n     (arst_n),
    .flag_first (flag_first),
    .pb_1_1     (pb_1_1),
    .pb_1_2     (pb_1_2),
    .pb_2_1     (pb_2_1),
    .pb_2_2     (pb_2_2),
    .pb_flag_1  (pb_flag_1),
    .pb_flag_2  (pb_flag_2),
    .flush      (flush),
    .low        (low),
    .cnt        (cnt),
    .out_byte_1 (out_byte_1),
    .out_byte_2 (out_byte_2),
    .out_byte_3 (out_byte_3),
    .out_byte_4 (out_byte_4),
    .out_byte_5 (out_byte_5),
    .out_count  (out_count),
    .out_last   (out_last)
  );

  bind s4_carry_top s4_carry_checker chk_i (
    .s4_clk      (s4_clk),
    .arst_n      (arst_n),
    .flush       (flush),
    .word_1      (word_1),
    .word_2      (word_2),
    .word_count  (word_count),
    .final_words (final_words),
    .out_count   (out_count),
    .out_last    (out_last)
  );

  task automatic fail_now(input string msg);
    begin
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "stopping at the first error");
    end
  endtask

  // ------------------------------
  // Random numbers
  // ------------------------------
  function automatic logic [31:0] galois_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = galois_step(lfsr_state);
    end
    return v;
  endfunction

  function automatic logic [1:0] pick_flag();
    logic [1:0] v;
    v = 2'(rand_bits(2));
    return (v == 2'd3) ? s4_code_pkg::lane_none : v;
  endfunction

  // Roughly three words in eight carry a 0xFF byte
  function automatic logic [8:0] pick_word();
    logic [7:0] b;
    logic       carry;
    b = (rand_bits(3) < 3) ? 8'hff : 8'(rand_bits(8));
    carry = (rand_bits(2) == 0);
    return {carry, b};
  endfunction

  function automatic logic is_run(input logic [8:0] w);
    return (w == {1'b0, s4_code_pkg::run_byte});
  endfunction

  // A fourth pending 0xFF gets its carry set instead
  function automatic logic [8:0] cap_run(input logic [8:0] w, input int r);
    if (is_run(w) && r >= 3) begin
      return {1'b1, w[7:0]};
    end
    return w;
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  task automatic apply_word(input logic [8:0] w);
    logic carry;
    begin
      carry = w[8];
      if (!carry && w[7:0] == s4_code_pkg::run_byte) begin
        run_cnt++;
      end else begin
        if (prev_vld) begin
          exp_q.push_back(8'(prev_byte + carry));
        end
        repeat (run_cnt) exp_q.push_back(8'(s4_code_pkg::run_byte + carry));
        prev_byte = w[7:0];
        prev_vld  = 1'b1;
        run_cnt   = 0;
      end
    end
  endtask

  task automatic model_flush(input logic [23:0] l, input logic [4:0] c);
    logic [63:0] e;
    int          s;
    begin
      e = (64'(l) + 64'(s4_code_pkg::flush_mask)) & ~64'(s4_code_pkg::flush_mask);
      e = e | (64'(s4_code_pkg::flush_mask) + 64'd1);
      s = int'(c) + 10;
      apply_word(9'(e >> (int'(c) + 16)));
      if (s > 8) begin
        apply_word({1'b0, 8'(e >> (int'(c) + 8))});
      end
      if (prev_vld) begin
        exp_q.push_back(prev_byte);
      end
      repeat (run_cnt) exp_q.push_back(s4_code_pkg::run_byte);
      prev_vld = 1'b0;
      run_cnt  = 0;
    end
  endtask

  // ------------------------------
  // Output comparison
  // ------------------------------
  function automatic logic [7:0] byte_at(input int i);
    case (i)
      0:       return out_byte_1;
      1:       return out_byte_2;
      2:       return out_byte_3;
      3:       return out_byte_4;
      default: return out_byte_5;
    endcase
  endfunction

  task automatic compare_outputs;
    logic [7:0] got;
    logic [7:0] want;
    begin
      assert (dut_i.chk_i.assert_fail !== 1'b1)
        else fail_now("a bound checker assertion failed");
      assert (!$isunknown(out_count) && int'(out_count) <= exp_q.size())
        else fail_now($sformatf("CHECK FAILED out_count got %h expected at most %h",
                                out_count, exp_q.size()));
      for (int i = 0; i < int'(out_count); i++) begin
        got  = byte_at(i);
        want = exp_q.pop_front();
        assert (got === want)
          else fail_now($sformatf("CHECK FAILED out_byte_%0d got %h expected %h",
                                  i + 1, got, want));
      end
      if (out_last === 1'b1) begin
        last_seen = 1'b1;
        assert (exp_q.size() == 0)
          else fail_now($sformatf("%0d expected bytes still queued when out_last rose",
                                  exp_q.size()));
      end
    end
  endtask

  task automatic next_cycle;
    begin
      @(negedge s4_clk);
      compare_outputs();
    end
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic send_cycle(input logic first, input logic [1:0] f1, input logic [8:0] a1,
                            input logic [8:0] a2, input logic [1:0] f2,
                            input logic [8:0] b1, input logic [8:0] b2);
    logic       sel_one;
    logic [1:0] use_flag;
    logic [8:0] u1;
    logic [8:0] u2;
    int         r;
    begin
      sel_one  = (f1 != s4_code_pkg::lane_none);
      use_flag = sel_one ? f1 : f2;
      r  = first ? 0 : run_cnt;
      u1 = cap_run(sel_one ? a1 : b1, r);
      r  = is_run(u1) ? r + 1 : 0;
      u2 = cap_run(sel_one ? a2 : b2, r);
      if (sel_one) begin
        a1 = u1;
        a2 = u2;
      end else begin
        b1 = u1;
        b2 = u2;
      end
      next_cycle();
      flag_first = first;
      pb_flag_1  = f1;
      pb_flag_2  = f2;
      pb_1_1     = a1;
      pb_1_2     = a2;
      pb_2_1     = b1;
      pb_2_2     = b2;
      flush      = 1'b0;
      if (first) begin
        prev_vld = 1'b0;
        run_cnt  = 0;
      end
      if (use_flag == s4_code_pkg::lane_one || use_flag == s4_code_pkg::lane_two) begin
        apply_word(u1);
      end
      if (use_flag == s4_code_pkg::lane_two) begin
        apply_word(u2);
      end
    end
  endtask

  task automatic send_flush(input logic [23:0] l, input logic [4:0] c);
    begin
      next_cycle();
      flag_first = 1'b0;
      pb_flag_1  = s4_code_pkg::lane_none;
      pb_flag_2  = s4_code_pkg::lane_none;
      flush      = 1'b1;
      low        = l;
      cnt        = c;
      model_flush(l, c);
      last_seen = 1'b0;
      next_cycle();
      flush = 1'b0;
      while (!last_seen) begin
        next_cycle();
      end
    end
  endtask

  task automatic run_directed_frame;
    begin
      send_cycle(1'b1, s4_code_pkg::lane_one, 9'h012, 9'h000,
                 s4_code_pkg::lane_none, 9'h000, 9'h000);
      // Both lanes flagged, lane 1 brings two pending 0xFF
      send_cycle(1'b0, s4_code_pkg::lane_two, 9'h0ff, 9'h0ff,
                 s4_code_pkg::lane_one, 9'h077, 9'h000);
      send_cycle(1'b0, s4_code_pkg::lane_none, 9'h000, 9'h000,
                 s4_code_pkg::lane_one, 9'h0ff, 9'h000);
      // Carry word settles the held byte and the three 0xFF
      send_cycle(1'b0, s4_code_pkg::lane_one, 9'h105, 9'h000,
                 s4_code_pkg::lane_two, 9'h0ff, 9'h0ff);
      send_cycle(1'b0, s4_code_pkg::lane_two, 9'h0ff, 9'h034,
                 s4_code_pkg::lane_none, 9'h000, 9'h000);
      // Second flush word is 0xFF and stays pending into the drain
      send_flush(24'h7f8001, 5'd7);
    end
  endtask

  task automatic run_random_frame;
    int         len;
    logic [1:0] f1;
    logic [1:0] f2;
    logic [8:0] w [4];
    logic [7:0] b;
    begin
      len = 2 + int'(rand_bits(3));
      for (int c = 0; c < len; c++) begin
        f1 = pick_flag();
        f2 = pick_flag();
        for (int k = 0; k < 4; k++) begin
          w[k] = pick_word();
        end
        if (c == 0 && f1 == s4_code_pkg::lane_none && f2 == s4_code_pkg::lane_none) begin
          f1 = s4_code_pkg::lane_one;
        end
        send_cycle(c == 0, f1, w[0], w[1], f2, w[2], w[3]);
      end
      // Closing word leaves no pending run before the flush
      b = 8'(rand_bits(8));
      if (b == s4_code_pkg::run_byte) begin
        b = 8'h00;
      end
      send_cycle(1'b0, s4_code_pkg::lane_one, {1'(rand_bits(1)), b}, 9'h000,
                 s4_code_pkg::lane_none, 9'h000, 9'h000);
      send_flush(24'(rand_bits(24)), 5'(rand_bits(3)));
    end
  endtask

  // ------------------------------
  // Main sequence and watchdog
  // ------------------------------
  initial begin
    lfsr_state = 32'h847d;
    last_seen  = 1'b0;
    prev_byte  = 8'h00;
    prev_vld   = 1'b0;
    run_cnt    = 0;
    flag_first = 1'b0;
    pb_1_1     = '0;
    pb_1_2     = '0;
    pb_2_1     = '0;
    pb_2_2     = '0;
    pb_flag_1  = s4_code_pkg::lane_none;
    pb_flag_2  = s4_code_pkg::lane_none;
    flush      = 1'b0;
    low        = '0;
    cnt        = '0;
    wait (arst_n === 1'b1);
    // Stray words inside the settle window would settle one byte if not masked
    pb_flag_1 = s4_code_pkg::lane_two;
    pb_1_1    = 9'h011;
    pb_1_2    = 9'h022;
    next_cycle();
    pb_flag_1 = s4_code_pkg::lane_none;
    repeat (s4_width_pkg::settle_cycles + 1) next_cycle();
    run_directed_frame();
    repeat (n_frames) run_random_frame();
    repeat (4) next_cycle();
    if (exp_q.size() == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      fail_now("expected bytes were never produced by the DUT");
    end
  end

  initial begin
    repeat (watch_cycles) @(posedge s4_clk);
    fail_now($sformatf("timeout after %0d cycles without finishing", watch_cycles));
  end

endmodule

`default_nettype wire
